/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = calculator_tb
FLIST = all.f

SRCS = $(shell grep -v '^+' $(FLIST))
BIN  = obj_dir/V$(TOP)
LOG  = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	-$(BIN) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
logic/calc_pkg.sv
logic/key_encoder.sv
logic/calc_core.sv
logic/bin_to_bcd.sv
logic/entry_line.sv
logic/result_line.sv
logic/lcd_sequencer.sv
logic/calculator_top.sv
tb/calculator_tb.sv

/* logic/bin_to_bcd.sv */
`timescale 1ns/100ps

module bin_to_bcd import calc_pkg::*;
(
    input  logic                    rst,
    input  logic                    clk_100hz,
    input  logic [calc_w-1:0]       result,
    input  logic                    conv_start,
    output logic [4*bcd_digits-1:0] bcd,
    output logic                    neg,
    output logic                    conv_done
);

    localparam int cnt_w = $clog2(calc_w + 1);

    logic [calc_w-1:0]       mag;
    logic [4*bcd_digits-1:0] adj;
    logic                    busy;
    logic [cnt_w-1:0]        cnt;

    // add-3 on every digit of 5 or more before the shift
    always_comb
    begin
        adj = bcd;
        for (int i = 0; i < bcd_digits; i++)
            if (adj[4*i +: 4] >= 4'd5)
                adj[4*i +: 4] = adj[4*i +: 4] + 4'd3;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            busy      <= 1'b0;
            cnt       <= '0;
            conv_done <= 1'b0;
        end
        else
        begin
            conv_done <= 1'b0;
            if (conv_start)
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
            else if (busy)
            begin
                if (cnt == cnt_w'(calc_w))
                begin
                    busy      <= 1'b0;
                    conv_done <= 1'b1;
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge rst)
    begin
        if (conv_start)
        begin
            neg <= result[calc_w-1];
            mag <= result[calc_w-1] ? -result : result;   // sign-magnitude
            bcd <= '0;
        end
        else if (busy && cnt != cnt_w'(calc_w))
        begin
            bcd <= {adj[4*bcd_digits-2:0], mag[calc_w-1]};
            mag <= mag << 1;
        end
    end

    for (genvar g = 0; g < bcd_digits; g++)
    begin : g_digit_chk
        a_digit_range: assert property (@(posedge rst) disable iff (clk_100hz)
            conv_done |-> bcd[4*g +: 4] <= 4'd9);
    end

endmodule

/* logic/calc_core.sv */
`timescale 1ns/100ps

module calc_core import calc_pkg::*;
(
    input  logic              rst,
    input  logic              clk_100hz,
    input  logic              digit_stb,
    input  logic [3:0]        digit,
    input  logic              sign_stb,
    input  logic              op_stb,
    input  op_t               op,
    input  logic              eq_stb,
    output logic              echo_stb,
    output chr_t              echo_char,
    output logic [calc_w-1:0] result,
    output logic              conv_start
);

    logic [calc_w-1:0] term_mag;
    logic              term_neg;
    logic              has_digit;   // term holds at least one digit
    logic              done;        // equals seen
    op_t               pend_op;
    logic [calc_w-1:0] term;
    logic [calc_w-1:0] acc_next;

    function automatic chr_t op_char(op_t o);
        case (o)
            op_add:  return chr_plus;
            op_sub:  return chr_minus;
            op_mul:  return chr_times;
            default: return chr_divide;
        endcase
    endfunction

    assign term = term_neg ? -term_mag : term_mag;

    always_comb
    begin
        case (pend_op)
            op_add:  acc_next = result + term;
            op_sub:  acc_next = result - term;
            op_mul:  acc_next = result * term;
            default:
                if (term == '0)
                    acc_next = '0;
                else
                    acc_next = $signed(result) / $signed(term);
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            result     <= '0;
            pend_op    <= op_add;
            term_mag   <= '0;
            term_neg   <= 1'b0;
            has_digit  <= 1'b0;
            done       <= 1'b0;
            echo_stb   <= 1'b0;
            echo_char  <= chr_blank;
            conv_start <= 1'b0;
        end
        else
        begin
            echo_stb   <= 1'b0;
            conv_start <= 1'b0;
            if (!done)
            begin
                if (digit_stb)
                begin
                    term_mag  <= term_mag * calc_w'(10) + calc_w'(digit);
                    has_digit <= 1'b1;
                    echo_stb  <= 1'b1;
                    echo_char <= chr_zero + chr_t'(digit);
                end
                else if (sign_stb && !has_digit)
                begin
                    term_neg  <= 1'b1;
                    echo_stb  <= 1'b1;
                    echo_char <= chr_minus;
                end
                else if ((op_stb || eq_stb) && has_digit)
                begin
                    result     <= acc_next;       // apply the pending operator
                    pend_op    <= op;
                    term_mag   <= '0;
                    term_neg   <= 1'b0;
                    has_digit  <= 1'b0;
                    echo_stb   <= 1'b1;
                    echo_char  <= eq_stb ? chr_equals : op_char(op);
                    done       <= eq_stb;
                    conv_start <= eq_stb;
                end
            end
        end
    end

endmodule

/* logic/calc_pkg.sv */
package calc_pkg;

    localparam int calc_w     = 32;
    localparam int bcd_digits = 10;   // enough for 2^32
    localparam int lcd_cols   = 16;

    typedef enum logic [1:0]
    {
        op_add,
        op_sub,
        op_mul,
        op_div
    } op_t;

    typedef logic [7:0] chr_t;

    // character rom codes of the display
    localparam chr_t chr_blank  = 8'h20;
    localparam chr_t chr_zero   = 8'h30;
    localparam chr_t chr_minus  = 8'h2D;
    localparam chr_t chr_plus   = 8'h2B;
    localparam chr_t chr_times  = 8'h78;
    localparam chr_t chr_divide = 8'hFD;
    localparam chr_t chr_equals = 8'h3D;

    // controller instruction bytes
    localparam chr_t cmd_function_set = 8'h3C;   // 8 bit bus, 2 lines
    localparam chr_t cmd_display_on   = 8'h0C;
    localparam chr_t cmd_entry_mode   = 8'h06;
    localparam chr_t cmd_return_home  = 8'h02;
    localparam chr_t cmd_line1_addr   = 8'h80;
    localparam chr_t cmd_line2_addr   = 8'hC0;

endpackage

/* logic/calculator_top.sv */
`timescale 1ns/100ps

module calculator_top import calc_pkg::*;
#(
    parameter int t_power_up = 70,
    parameter int t_command  = 30,
    parameter int t_refresh  = 400,
    parameter int t_clear    = 200
)
(
    input  logic       rst,
    input  logic       clk_100hz,
    input  logic [9:0] key_digit,
    input  logic       key_sign,
    input  logic [3:0] key_op,
    input  logic       key_eq,
    output logic       lcd_rs,
    output logic       lcd_rw,
    output logic [7:0] lcd_data,
    output logic       lcd_e
);

    logic                    digit_stb;
    logic [3:0]              digit;
    logic                    sign_stb;
    logic                    op_stb;
    op_t                     op;
    logic                    eq_stb;
    logic                    echo_stb;
    chr_t                    echo_char;
    logic [calc_w-1:0]       result;
    logic                    conv_start;
    logic [4*bcd_digits-1:0] bcd;
    logic                    neg;
    logic                    conv_done;
    chr_t [lcd_cols-1:0]     line1;
    chr_t [lcd_cols-1:0]     line2;

    key_encoder i_key_encoder
    (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .key_digit (key_digit),
        .key_sign  (key_sign),
        .key_op    (key_op),
        .key_eq    (key_eq),
        .digit_stb (digit_stb),
        .digit     (digit),
        .sign_stb  (sign_stb),
        .op_stb    (op_stb),
        .op        (op),
        .eq_stb    (eq_stb)
    );

    calc_core i_calc_core
    (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .digit_stb  (digit_stb),
        .digit      (digit),
        .sign_stb   (sign_stb),
        .op_stb     (op_stb),
        .op         (op),
        .eq_stb     (eq_stb),
        .echo_stb   (echo_stb),
        .echo_char  (echo_char),
        .result     (result),
        .conv_start (conv_start)
    );

    bin_to_bcd i_bin_to_bcd
    (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .result     (result),
        .conv_start (conv_start),
        .bcd        (bcd),
        .neg        (neg),
        .conv_done  (conv_done)
    );

    entry_line i_entry_line
    (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .echo_stb  (echo_stb),
        .echo_char (echo_char),
        .line1     (line1)
    );

    result_line i_result_line
    (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .bcd       (bcd),
        .neg       (neg),
        .conv_done (conv_done),
        .line2     (line2)
    );

    lcd_sequencer #(
        .t_power_up (t_power_up),
        .t_command  (t_command),
        .t_refresh  (t_refresh),
        .t_clear    (t_clear)
    ) i_lcd_sequencer
    (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .line1     (line1),
        .line2     (line2),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_data  (lcd_data),
        .lcd_e     (lcd_e)
    );

endmodule

/* logic/entry_line.sv */
`timescale 1ns/100ps

module entry_line import calc_pkg::*;
(
    input  logic                rst,
    input  logic                clk_100hz,
    input  logic                echo_stb,
    input  chr_t                echo_char,
    output chr_t [lcd_cols-1:0] line1
);

    localparam int col_w = $clog2(lcd_cols + 1);

    logic [col_w-1:0] col;   // next free column

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            line1 <= {lcd_cols{chr_blank}};
            col   <= '0;
        end
        else if (echo_stb && col < col_w'(lcd_cols))
        begin
            line1[col] <= echo_char;
            col        <= col + 1'b1;
        end
    end

endmodule

/* logic/key_encoder.sv */
`timescale 1ns/100ps

module key_encoder import calc_pkg::*;
(
    input  logic       rst,
    input  logic       clk_100hz,
    input  logic [9:0] key_digit,
    input  logic       key_sign,
    input  logic [3:0] key_op,
    input  logic       key_eq,
    output logic       digit_stb,
    output logic [3:0] digit,
    output logic       sign_stb,
    output logic       op_stb,
    output op_t        op,
    output logic       eq_stb
);

    logic [9:0] digit_q;
    logic       sign_q;
    logic [3:0] op_q;
    logic       eq_q;
    logic [3:0] grp;          // digit, sign, op, eq
    logic [3:0] grp_q;
    logic [3:0] rise;
    logic [3:0] digit_enc;
    op_t        op_enc;

    assign grp  = {|digit_q, sign_q, |op_q, eq_q};
    assign rise = grp & ~grp_q;

    // lowest index wins
    always_comb
    begin
        digit_enc = 4'd0;
        op_enc    = op_add;
        for (int i = 9; i >= 0; i--)
            if (digit_q[i])
                digit_enc = 4'(i);
        for (int j = 3; j >= 0; j--)
            if (op_q[j])
                op_enc = op_t'(2'(j));
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            digit_q   <= '0;
            sign_q    <= 1'b0;
            op_q      <= '0;
            eq_q      <= 1'b0;
            grp_q     <= '0;
            digit_stb <= 1'b0;
            sign_stb  <= 1'b0;
            op_stb    <= 1'b0;
            eq_stb    <= 1'b0;
        end
        else
        begin
            digit_q   <= key_digit;
            sign_q    <= key_sign;
            op_q      <= key_op;
            eq_q      <= key_eq;
            grp_q     <= grp;
            digit_stb <= rise[3];
            sign_stb  <= rise[2] & ~rise[3];
            op_stb    <= rise[1] & ~|rise[3:2];
            eq_stb    <= rise[0] & ~|rise[3:1];
        end
    end

    always_ff @(posedge rst)
    begin
        digit <= digit_enc;
        op    <= op_enc;
    end

    // encoded digit was one of the sampled keys
    a_digit_held: assert property (@(posedge rst) disable iff (clk_100hz)
        digit_stb |-> (($past(digit_q) >> digit) & 10'd1) != '0);

endmodule

/* logic/lcd_sequencer.sv */
`timescale 1ns/100ps

module lcd_sequencer import calc_pkg::*;
#(
    parameter int t_power_up = 70,
    parameter int t_command  = 30,
    parameter int t_refresh  = 400,
    parameter int t_clear    = 200
)
(
    input  logic                rst,
    input  logic                clk_100hz,
    input  chr_t [lcd_cols-1:0] line1,
    input  chr_t [lcd_cols-1:0] line2,
    output logic                lcd_rs,
    output logic                lcd_rw,
    output logic [7:0]          lcd_data,
    output logic                lcd_e
);

    localparam int t_line = 20;   // address, 16 chars, then idle
    localparam int cnt_w  = $clog2(t_power_up + t_command + t_refresh + t_clear + t_line + 1);

    typedef enum logic [2:0]
    {
        st_power_up,
        st_function_set,
        st_display_on,
        st_entry_mode,
        st_line1,
        st_line2,
        st_refresh,
        st_clear
    } seq_state_t;

    seq_state_t          state;
    seq_state_t          state_next;
    logic [cnt_w-1:0]    cnt;
    logic [cnt_w-1:0]    limit;
    chr_t                cmd;
    chr_t [lcd_cols-1:0] cur_line;
    int                  col;
    logic                wr;
    logic                rs;
    chr_t                data;

    always_comb
    begin
        case (state)
            st_power_up:     limit = cnt_w'(t_power_up);
            st_function_set,
            st_display_on,
            st_entry_mode:   limit = cnt_w'(t_command);
            st_line1,
            st_line2:        limit = cnt_w'(t_line);
            st_refresh:      limit = cnt_w'(t_refresh);
            default:         limit = cnt_w'(t_clear);
        endcase
        case (state)
            st_power_up:     state_next = st_function_set;
            st_function_set: state_next = st_display_on;
            st_display_on:   state_next = st_entry_mode;
            st_entry_mode:   state_next = st_line1;
            st_line1:        state_next = st_line2;
            st_line2:        state_next = st_refresh;
            st_refresh:      state_next = st_clear;
            default:         state_next = st_line1;   // refresh loop
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state <= st_power_up;
            cnt   <= '0;
        end
        else if (cnt == limit)
        begin
            state <= state_next;
            cnt   <= '0;
        end
        else
            cnt <= cnt + 1'b1;
    end

    // bus word for this cycle
    always_comb
    begin
        wr       = 1'b0;
        rs       = 1'b1;
        data     = '0;
        cur_line = (state == st_line1) ? line1 : line2;
        col      = int'(cnt) - 1;
        case (state)
            st_function_set: cmd = cmd_function_set;
            st_display_on:   cmd = cmd_display_on;
            st_entry_mode:   cmd = cmd_entry_mode;
            st_refresh:      cmd = cmd_return_home;
            st_line1:        cmd = cmd_line1_addr;
            st_line2:        cmd = cmd_line2_addr;
            default:         cmd = '0;
        endcase
        if (cnt == '0 && state != st_power_up && state != st_clear)
        begin
            wr   = 1'b1;
            rs   = 1'b0;
            data = cmd;
        end
        else if ((state == st_line1 || state == st_line2) && col < lcd_cols)
        begin
            wr   = 1'b1;
            data = cur_line[col];   // col 0 is the leftmost character
        end
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            lcd_rs   <= 1'b1;
            lcd_rw   <= 1'b1;
            lcd_data <= '0;
            lcd_e    <= 1'b0;
        end
        else
        begin
            lcd_rs   <= rs;
            lcd_rw   <= ~wr;
            lcd_data <= data;
            lcd_e    <= wr;
        end
    end

    // a line address is followed at once by that line's first character
    a_addr_then_data: assert property (@(posedge rst) disable iff (clk_100hz)
        lcd_e && !lcd_rs && (lcd_data == cmd_line1_addr || lcd_data == cmd_line2_addr)
            |=> lcd_e && lcd_rs);

endmodule

/* logic/result_line.sv */
`timescale 1ns/100ps

module result_line import calc_pkg::*;
(
    input  logic                    rst,
    input  logic                    clk_100hz,
    input  logic [4*bcd_digits-1:0] bcd,
    input  logic                    neg,
    input  logic                    conv_done,
    output chr_t [lcd_cols-1:0]     line2
);

    int                  msd;    // most significant nonzero digit
    chr_t [lcd_cols-1:0] text;

    always_comb
    begin
        msd  = 0;
        text = {lcd_cols{chr_blank}};
        for (int i = 0; i < bcd_digits; i++)
            if (bcd[4*i +: 4] != 4'd0)
                msd = i;
        // digit i sits i columns left of the right edge
        for (int i = 0; i < bcd_digits; i++)
            if (i <= msd)
                text[lcd_cols-1-i] = chr_zero + chr_t'(bcd[4*i +: 4]);
        if (neg)
            text[lcd_cols-2-msd] = chr_minus;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
            line2 <= {lcd_cols{chr_blank}};
        else if (conv_done)
            line2 <= text;
    end

endmodule

/* tb/calc_vectors.txt */
# keys: 0-9 digits, n sign key, + - * / operators, = equals
# columns: keys, expected line 1, expected line 2 (_ is a blank line, / is the divide glyph)
12+34=              12+34=            46
n5-20=              -5-20=            -25
3-10=               3-10=             -7
2+3*4=              2+3x4=            20
7/2=                7/2=              3
9/0=                9/0=              0
n7/2=               -7/2=             -3
10-4/3=             10-4/3=           2
++1-+2=             1-2=              -1
12=34+              12=               12
5n3=                53=               53
=+n                 -                 _
1234567890+123456=  1234567890+12345  1234691346
100000*100000=      100000x100000=    1410065408
50000*50000=        50000x50000=      -1794967296
n2147483648=        -2147483648=      -2147483648

/* tb/calculator_tb.sv */
`timescale 1ns/100ps

module calculator_tb;

    localparam int p_power_up = 4;
    localparam int p_command  = 2;
    localparam int p_refresh  = 10;
    localparam int p_clear    = 5;
    localparam logic [7:0] divide_glyph = 8'hFD;

    logic       rst;          // design clock
    logic       clk_100hz;    // async reset
    logic [9:0] key_digit;
    logic       key_sign;
    logic [3:0] key_op;
    logic       key_eq;
    logic       lcd_rs;
    logic       lcd_rw;
    logic [7:0] lcd_data;
    logic       lcd_e;

    string      vec_keys[$];
    string      vec_line1[$];
    string      vec_line2[$];
    logic [7:0] disp[2][16];   // decoded lcd contents
    logic [7:0] cmd_log[$];
    int         line_sel;
    int         col;
    int         home_cnt;
    int         cycles;
    int         cycle_limit;
    int         base;
    int         loop_cycles;
    int         init_cycles;

    calculator_top #(
        .t_power_up (p_power_up),
        .t_command  (p_command),
        .t_refresh  (p_refresh),
        .t_clear    (p_clear)
    ) i_dut
    (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .key_digit (key_digit),
        .key_sign  (key_sign),
        .key_op    (key_op),
        .key_eq    (key_eq),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_data  (lcd_data),
        .lcd_e     (lcd_e)
    );

    initial
    begin
        rst = 1'b0;
        forever #20 rst = ~rst;
    end

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // bus monitor, address byte picks the line
    always @(negedge rst)
    begin
        if (clk_100hz)
        begin
            home_cnt = 0;
            line_sel = 0;
            col      = 0;
            cmd_log.delete();
            for (int r = 0; r < 2; r++)
                for (int c = 0; c < 16; c++)
                    disp[r][c] = 8'h00;
        end
        else if (lcd_e)
        begin
            check("lcd_rw", 128'(lcd_rw), 128'(1'b0));
            if (!lcd_rs)
            begin
                cmd_log.push_back(lcd_data);
                if (lcd_data == 8'h80)
                begin
                    line_sel = 0;
                    col      = 0;
                end
                else if (lcd_data == 8'hC0)
                begin
                    line_sel = 1;
                    col      = 0;
                end
                else if (lcd_data == 8'h02)
                    home_cnt++;   // one refresh loop done
            end
            else if (col < 16)
            begin
                disp[line_sel][col] = lcd_data;
                col++;
            end
        end
    end

    always @(posedge rst)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: display not refreshed after %0d cycles", cycles);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [127:0] shown(int r);
        logic [127:0] v;
        for (int c = 0; c < 16; c++)
            v[127-8*c -: 8] = disp[r][c];
        return v;
    endfunction

    // column 0 lands in the top byte
    function automatic logic [127:0] line_text(string s, bit right);
        logic [127:0] v;
        int           off;
        byte          ch;
        v = {16{8'h20}};
        if (s == "_")
            s = "";
        off = right ? 16 - s.len() : 0;
        for (int c = 0; c < 16; c++)
            if (c >= off && c - off < s.len())
            begin
                ch = s[c - off];
                v[127-8*c -: 8] = (ch == "/") ? divide_glyph : ch;
            end
        return v;
    endfunction

    task automatic release_keys();
        key_digit = '0;
        key_sign  = 1'b0;
        key_op    = '0;
        key_eq    = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge rst);
        clk_100hz = 1'b1;
        release_keys();
        repeat (5) @(negedge rst);
        clk_100hz = 1'b0;
    endtask

    task automatic press_key(input byte c);
        release_keys();
        if (c >= "0" && c <= "9")
            key_digit[c - "0"] = 1'b1;
        else
            case (c)
                "n": key_sign = 1'b1;
                "+": key_op[0] = 1'b1;
                "-": key_op[1] = 1'b1;
                "*": key_op[2] = 1'b1;
                "/": key_op[3] = 1'b1;
                "=": key_eq = 1'b1;
                default:
                begin
                    $display("unknown key character %c in the vectors file", c);
                    $display("Test failures found");
                    $fatal(1, "bad vector");
                end
            endcase
        repeat (3) @(negedge rst);
        release_keys();
        repeat (3) @(negedge rst);
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string text;
        string k;
        string e1;
        string e2;
        fd = $fopen("tb/calc_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("could not open tb/calc_vectors.txt");
            $display("Test failures found");
            $fatal(1, "no vectors file");
        end
        while (!$feof(fd))
        begin
            text = "";
            n = $fgets(text, fd);
            if (n > 0 && text.len() > 0 && text[0] != "#")
            begin
                n = $sscanf(text, "%s %s %s", k, e1, e2);
                if (n == 3)
                begin
                    vec_keys.push_back(k);
                    vec_line1.push_back(e1);
                    vec_line2.push_back(e2);
                end
            end
        end
        $fclose(fd);
        if (vec_keys.size() == 0)
        begin
            $display("the vectors file holds no tests");
            $display("Test failures found");
            $fatal(1, "empty vectors file");
        end
    endtask

    initial
    begin
        clk_100hz = 1'b1;
        release_keys();
        cycles = 0;
        load_vectors();

        // reset, power-up and a few refresh loops per test
        loop_cycles = 2 * 21 + (p_refresh + 1) + (p_clear + 1);
        init_cycles = 5 + (p_power_up + 1) + 3 * (p_command + 1);
        cycle_limit = init_cycles + 2 * loop_cycles;
        foreach (vec_keys[i])
            cycle_limit += init_cycles + vec_keys[i].len() * 6 + 200 + 3 * loop_cycles;

        apply_reset();
        check("lcd_rs", 128'(lcd_rs), 128'(1'b1));
        check("lcd_rw", 128'(lcd_rw), 128'(1'b1));
        check("lcd_e", 128'(lcd_e), 128'(1'b0));
        wait (home_cnt >= 1);
        check("function set", 128'(cmd_log[0]), 128'(8'h3C));
        check("display on", 128'(cmd_log[1]), 128'(8'h0C));
        check("entry mode", 128'(cmd_log[2]), 128'(8'h06));
        check("line1 idle", shown(0), {16{8'h20}});
        check("line2 idle", shown(1), {16{8'h20}});

        foreach (vec_keys[i])
        begin
            apply_reset();
            for (int k = 0; k < vec_keys[i].len(); k++)
                press_key(vec_keys[i][k]);
            base = home_cnt;
            wait (home_cnt >= base + 3);   // two full loops after the partial one
            check($sformatf("line1 for %s", vec_keys[i]), shown(0),
                  line_text(vec_line1[i], 1'b0));
            check($sformatf("line2 for %s", vec_keys[i]), shown(1),
                  line_text(vec_line2[i], 1'b1));
        end

        $display("All tests passed!");
        $finish;
    end

endmodule
